/* fma_wb.f */
+incdir+include
source/fma_pkg.sv
source/fma_multiplier.sv
source/fma_aligner.sv
source/fma_add_norm.sv
source/fma_rounder.sv
source/fma_core.sv
source/fma_wb.sv
bench/fma_clk_gen.sv
bench/fma_checker.sv
bench/fma_wb_tb.sv

/* bench/fma_wb_tb.sv */
`timescale 1ns/1ps
`include "fma_consts.svh"

module fma_wb_tb;

    import fma_pkg::*;

    localparam int CLK_NS       = 10;
    localparam int RESET_CYCLES = 16;
    localparam int N_FIXED      = 10;
    localparam int N_RAND       = 14;
    localparam int N_ROWS       = N_FIXED + N_RAND;
    localparam int MAX_POLLS    = 16;
    // Reset test counts as one more row
    localparam int WATCHDOG_NS  = ((N_ROWS + 1) * 40 + RESET_CYCLES) * CLK_NS;

    logic        clk;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    int          test_num;
    logic [31:0] exp_result;
    logic [31:0] exp_status;
    int          bench_errs;     // Failures found by the bus tasks
    logic [31:0] rng_state;
    int          tests;
    int          failed;
    int          errors;
    int          reqs;
    int          acks;

    // Stimulus table
    logic [31:0] tab_a   [N_ROWS];
    logic [31:0] tab_b   [N_ROWS];
    logic [31:0] tab_c   [N_ROWS];
    logic [31:0] tab_res [N_ROWS];
    logic [31:0] tab_st  [N_ROWS];
    logic        tab_restart [N_ROWS];   // Second start while busy

    fma_clk_gen fma_clk_gen_inst (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fma_wb fma_wb_inst (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    fma_checker fma_checker_inst (
        .clk_i        (clk),
        .wb_req_i     (wb_req),
        .wb_rsp_i     (wb_rsp),
        .test_num_i   (test_num),
        .exp_result_i (exp_result),
        .exp_status_i (exp_status),
        .tests_o      (tests),
        .failed_o     (failed),
        .errors_o     (errors),
        .reqs_o       (reqs),
        .acks_o       (acks)
    );

    ////////////////////////////////////////////////////////////
    // Reference helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Exact for |v| < 2^24
    function automatic logic [31:0] int_to_float(input int v);
        logic [31:0] mag;
        logic [31:0] w;
        int          p;
        w = '0;
        if (v != 0) begin
            mag = (v < 0) ? -v : v;
            p = 0;
            for (int k = 0; k < 32; k++) begin
                if (mag[k]) begin
                    p = k;          // Leading one
                end
            end
            w[31]    = (v < 0);
            w[30:23] = 8'(127 + p);
            w[22:0]  = 23'(mag << (23 - p));   // Hidden bit falls off the top
        end
        return w;
    endfunction

    // Signed integer, magnitude below 1024
    task automatic draw_operand(output int v);
        rng_state = xorshift32(rng_state);
        v = int'(rng_state[9:0]);
        if (rng_state[10]) begin
            v = -v;
        end
    endtask

    task automatic set_row(input int r, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] c, input logic [31:0] res,
                           input logic [31:0] st, input logic restart);
        tab_a[r]       = a;
        tab_b[r]       = b;
        tab_c[r]       = c;
        tab_res[r]     = res;
        tab_st[r]      = st;
        tab_restart[r] = restart;
    endtask

    task automatic fill_table();
        int a;
        int b;
        int c;
        // Exact cases, then alignment ends, rounding, overflow, flushing
        set_row(0, 32'h3F80_0000, 32'h4000_0000, 32'h4040_0000, 32'h40E0_0000, 32'h2, 1'b0);
        set_row(1, 32'h3F00_0000, 32'h3E80_0000, 32'h4080_0000, 32'h3FC0_0000, 32'h2, 1'b0);
        set_row(2, 32'hC0C0_0000, 32'h4000_0000, 32'h4040_0000, 32'h0000_0000, 32'h2, 1'b0);
        set_row(3, 32'hC120_0000, 32'h4000_0000, 32'h4040_0000, 32'hC080_0000, 32'h2, 1'b0);
        set_row(4, 32'h7180_0000, 32'h3FC0_0000, 32'h3F80_0000, 32'h7180_0000, 32'h2, 1'b0);
        set_row(5, 32'h3F80_0000, 32'h5880_0000, 32'h3FC0_0000, 32'h58C0_0000, 32'h2, 1'b0);
        set_row(6, 32'h3F80_0000, 32'h3380_0000, 32'h3F80_0000, 32'h3F80_0000, 32'h2, 1'b0);
        set_row(7, 32'h3F80_0000, 32'h7180_0000, 32'h7180_0000, 32'h7F80_0000, 32'h6, 1'b0);
        set_row(8, 32'h4040_0000, 32'h0000_0123, 32'h4000_0000, 32'h4040_0000, 32'h2, 1'b0);
        set_row(9, 32'h3F80_0000, 32'h4000_0000, 32'h4040_0000, 32'h40E0_0000, 32'h2, 1'b1);
        for (int r = N_FIXED; r < N_ROWS; r++) begin
            draw_operand(a);
            draw_operand(b);
            draw_operand(c);
            set_row(r, int_to_float(a), int_to_float(b), int_to_float(c),
                    int_to_float(a + b * c), 32'h2, 1'b0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Wishbone master
    ////////////////////////////////////////////////////////////
    task automatic bus_access(input logic we, input logic [6:0] byte_adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);             // stb stays low across at least one edge
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = byte_adr[6:2];
        wb_req.dat = wdata;
        @(posedge clk);
        #1;
        while (!wb_rsp.ack) begin
            @(posedge clk);
            #1;
        end
        rdata      = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic write_reg(input logic [6:0] byte_adr, input logic [31:0] wdata);
        logic [31:0] unused;
        bus_access(1'b1, byte_adr, wdata, unused);
    endtask

    task automatic read_reg(input logic [6:0] byte_adr, output logic [31:0] rdata);
        bus_access(1'b0, byte_adr, 32'h0, rdata);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[1] && polls < MAX_POLLS) begin
            read_reg(`FMA_ADDR_STATUS, st);
            polls++;
        end
        if (!st[1]) begin
            $display("Test %0d: STATUS never reported done after %0d polls", test_num, polls);
            bench_errs++;
        end
    endtask

    task automatic run_row(input int r);
        logic [31:0] rdata;
        write_reg(`FMA_ADDR_A, tab_a[r]);
        write_reg(`FMA_ADDR_B, tab_b[r]);
        write_reg(`FMA_ADDR_C, tab_c[r]);
        // Previous RESULT read is checked by now
        test_num   = r + 1;
        exp_result = tab_res[r];
        exp_status = tab_st[r];
        write_reg(`FMA_ADDR_CTRL, 32'h1);
        if (tab_restart[r]) begin
            write_reg(`FMA_ADDR_A, 32'h4120_0000);   // 10.0, must not reach the result
            write_reg(`FMA_ADDR_CTRL, 32'h1);        // Core still busy
        end
        wait_done();
        read_reg(`FMA_ADDR_RESULT, rdata);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] rdata;
        int          total;
        wb_req     = '0;
        test_num   = 0;
        exp_result = '0;
        exp_status = '0;
        bench_errs = 0;
        rng_state  = 32'h2ad3;
        fill_table();
        @(posedge rst_n);
        // Test 0, state straight out of reset
        read_reg(`FMA_ADDR_STATUS, rdata);
        read_reg(`FMA_ADDR_RESULT, rdata);
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        repeat (2) @(posedge clk);   // Last ack through the monitor
        total = errors + bench_errs;
        if (reqs != acks) begin
            $display("Bus requests (%0d) and acks (%0d) do not match", reqs, acks);
            total++;
        end
        if (tests != N_ROWS + 1) begin
            $display("Only %0d of %0d tests reached their RESULT read", tests, N_ROWS + 1);
            total++;
        end
        $display("Tests %0d, failed %0d, check errors %0d, bench errors %0d",
                 tests, failed, errors, bench_errs);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog: run still going after %0d ns, DUT or bus hung", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* bench/fma_checker.sv */
`timescale 1ns/1ps
`include "fma_consts.svh"

module fma_checker (
    input  logic             clk_i,
    input  fma_pkg::wb_req_t wb_req_i,
    input  fma_pkg::wb_rsp_t wb_rsp_i,
    input  int               test_num_i,
    input  logic [31:0]      exp_result_i,
    input  logic [31:0]      exp_status_i,   // Status once busy has cleared
    output int               tests_o,
    output int               failed_o,
    output int               errors_o,
    output int               reqs_o,
    output int               acks_o
);

    import fma_pkg::*;

    logic       pending;        // Request seen and ack still owed
    logic       pend_we;
    logic [6:0] pend_adr;       // Byte address of that request
    int         test_errs;

    initial begin
        tests_o   = 0;
        failed_o  = 0;
        errors_o  = 0;
        reqs_o    = 0;
        acks_o    = 0;
        test_errs = 0;
        pending   = 1'b0;
        pend_we   = 1'b0;
        pend_adr  = '0;
    end

    ////////////////////////////////////////////////////////////
    // Read data compare
    ////////////////////////////////////////////////////////////
    task automatic check_read(input logic [6:0] adr, input logic [31:0] data);
        // Mid-run polls show busy alone and are skipped
        if (adr == `FMA_ADDR_STATUS && (!data[0] || data[1] || test_num_i == 0)) begin
            if (data !== exp_status_i) begin
                $display("Error: test %0d wb_rsp_o.dat (STATUS) got 0x%08h expected 0x%08h",
                         test_num_i, data, exp_status_i);
                errors_o++;
                test_errs++;
            end
        end else if (adr == `FMA_ADDR_RESULT) begin
            if (data !== exp_result_i) begin
                $display("Error: test %0d wb_rsp_o.dat (RESULT) got 0x%08h expected 0x%08h",
                         test_num_i, data, exp_result_i);
                errors_o++;
                test_errs++;
            end
            // RESULT read closes a test
            $display("Test %0d %s, result 0x%08h", test_num_i,
                     (test_errs == 0) ? "passed" : "failed", data);
            tests_o++;
            if (test_errs != 0) begin
                failed_o++;
            end
            test_errs = 0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus monitor sampling mid-cycle
    ////////////////////////////////////////////////////////////
    always @(negedge clk_i) begin
        if (wb_rsp_i.ack) begin
            if (!pending) begin
                $display("Test %0d: ack seen with no request outstanding", test_num_i);
                errors_o++;
                test_errs++;
            end else begin
                acks_o++;
                pending = 1'b0;
                if (!pend_we) begin
                    check_read(pend_adr, wb_rsp_i.dat);
                end
            end
        end
        // Master drops stb right after ack, so a held stb here is a new request
        if (wb_req_i.cyc && wb_req_i.stb && !pending && !wb_rsp_i.ack) begin
            pending  = 1'b1;
            pend_we  = wb_req_i.we;
            pend_adr = {wb_req_i.adr, 2'b00};
            reqs_o++;
        end
    end

endmodule

/* bench/fma_clk_gen.sv */
`timescale 1ns/1ps

module fma_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_NS      = 5;    // 10 ns period
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #HALF_NS clk_o = ~clk_o;
    end

    // Release lands just after an edge, like every other bench input
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

/* source/fma_wb.sv */
`timescale 1ns/1ps
`include "fma_consts.svh"

module fma_wb (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  fma_pkg::wb_req_t wb_req_i,
    output fma_pkg::wb_rsp_t wb_rsp_o
);

    import fma_pkg::*;

    fp_word_t    a_q, b_q, c_q;     // Operand registers
    fp_word_t    core_result;
    logic        core_busy;
    logic        core_done;
    logic        core_ovf;
    logic        req;               // New request not yet acked
    logic        wr;
    logic [6:0]  byte_adr;
    logic        ack_q;
    logic        start_q;
    logic        done_q;            // Sticky until next start
    logic        ovf_q;
    logic [31:0] rdata;
    logic [31:0] rdata_q;

    ////////////////////////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////////////////////////
    assign req      = wb_req_i.cyc & wb_req_i.stb & ~ack_q;   // Ack lasts one clock
    assign wr       = req & wb_req_i.we;
    assign byte_adr = {wb_req_i.adr, 2'b00};

    // Writes land with the ack
    always_ff @(posedge clk_i) begin
        if (wr && byte_adr == `FMA_ADDR_A) a_q <= wb_req_i.dat;
        if (wr && byte_adr == `FMA_ADDR_B) b_q <= wb_req_i.dat;
        if (wr && byte_adr == `FMA_ADDR_C) c_q <= wb_req_i.dat;
    end

    always_comb begin
        case (byte_adr)
            `FMA_ADDR_A:      rdata = a_q;
            `FMA_ADDR_B:      rdata = b_q;
            `FMA_ADDR_C:      rdata = c_q;
            `FMA_ADDR_STATUS: rdata = {29'd0, ovf_q, done_q, core_busy};
            `FMA_ADDR_RESULT: rdata = core_result;
            default:          rdata = '0;   // CTRL and holes
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q   <= 1'b0;
            start_q <= 1'b0;
            done_q  <= 1'b0;
            ovf_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            ack_q   <= req;
            // Start dropped while the core works
            start_q <= wr & (byte_adr == `FMA_ADDR_CTRL) & wb_req_i.dat[0] & ~core_busy;
            if (start_q) begin
                done_q <= 1'b0;
                ovf_q  <= 1'b0;
            end else if (core_done) begin
                done_q <= 1'b1;
                ovf_q  <= core_ovf;
            end
            if (req) begin
                rdata_q <= rdata;   // Read data rides with ack
            end
        end
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rdata_q};

    fma_core fma_core_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .start_i    (start_q),
        .a_i        (a_q),
        .b_i        (b_q),
        .c_i        (c_q),
        .busy_o     (core_busy),
        .done_o     (core_done),
        .result_o   (core_result),
        .overflow_o (core_ovf)
    );

endmodule

/* source/fma_core.sv */
`timescale 1ns/1ps

module fma_core (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              start_i,
    input  fma_pkg::fp_word_t a_i,
    input  fma_pkg::fp_word_t b_i,
    input  fma_pkg::fp_word_t c_i,
    output logic              busy_o,
    output logic              done_o,
    output fma_pkg::fp_word_t result_o,
    output logic              overflow_o
);

    import fma_pkg::*;

    fp_word_t    a_f, b_f, c_f;      // Flushed operands
    product_cs_t prod_raw, prod_al;
    product_cs_t prod_q;
    align_t      align_d, align_q;
    norm_t       norm_d, norm_q;
    fp_word_t    result_d;
    logic        ovf_d;
    logic        accept;
    logic [2:0]  valid_q;            // One bit per stage

    // Subnormal in, signed zero out
    function automatic fp_word_t flush(input fp_word_t w);
        fp_word_t f;
        f = w;
        if (w.exp == '0) begin
            f.frac = '0;
        end
        return f;
    endfunction

    assign a_f = flush(a_i);
    assign b_f = flush(b_i);
    assign c_f = flush(c_i);

    assign accept = start_i & ~busy_o;   // One operation in flight

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////
    fma_multiplier fma_multiplier_inst (
        .b_mant_i (({|b_f.exp, b_f.frac})),
        .c_mant_i (({|c_f.exp, c_f.frac})),
        .prod_o   (prod_raw)
    );

    fma_aligner fma_aligner_inst (
        .a_i     (a_f),
        .b_i     (b_f),
        .c_i     (c_f),
        .prod_i  (prod_raw),
        .align_o (align_d),
        .prod_o  (prod_al)
    );

    fma_add_norm fma_add_norm_inst (
        .align_i (align_q),
        .prod_i  (prod_q),
        .norm_o  (norm_d)
    );

    fma_rounder fma_rounder_inst (
        .norm_i     (norm_q),
        .result_o   (result_d),
        .overflow_o (ovf_d)
    );

    // Stage payloads, loaded only when their stage fires
    always_ff @(posedge clk_i) begin
        if (accept) begin
            align_q <= align_d;
            prod_q  <= prod_al;
        end
        if (valid_q[0]) begin
            norm_q <= norm_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // Control and output register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q    <= '0;
            result_o   <= '0;
            overflow_o <= 1'b0;
        end else begin
            valid_q <= {valid_q[1:0], accept};
            if (valid_q[1]) begin          // Rounder result lands with done
                result_o   <= result_d;
                overflow_o <= ovf_d;
            end
        end
    end

    assign busy_o = |valid_q;
    assign done_o = valid_q[2];   // Three cycles after start

endmodule

/* source/fma_rounder.sv */
`timescale 1ns/1ps
`include "fma_consts.svh"

module fma_rounder (
    input  fma_pkg::norm_t    norm_i,
    output fma_pkg::fp_word_t result_o,
    output logic              overflow_o
);

    localparam int SIG_W = `FMA_MANT_W + 1;
    localparam int EW    = `FMA_EXP_W + 2;

    localparam logic signed [EW-1:0] EXP_MAX = (1 << `FMA_EXP_W) - 2;   // 254

    logic [SIG_W-1:0]     sig;
    logic                 guard;
    logic                 round_bit;
    logic                 round_up;
    logic [SIG_W:0]       sig_rnd;
    logic signed [EW-1:0] exp_rnd;

    assign {sig, guard, round_bit} = norm_i.mant;

    // Nearest, ties to even
    assign round_up = guard & (round_bit | norm_i.sticky | sig[0]);
    assign sig_rnd  = {1'b0, sig} + round_up;

    // Carry out leaves 1.000, fraction bits already zero
    assign exp_rnd = norm_i.exp + $signed({{(EW-1){1'b0}}, sig_rnd[SIG_W]});

    always_comb begin
        overflow_o = 1'b0;
        if (norm_i.zero) begin
            result_o = '{sign: norm_i.sign, exp: '0, frac: '0};
        end else if (exp_rnd > EXP_MAX) begin
            result_o   = '{sign: norm_i.sign, exp: '1, frac: '0};   // Infinity
            overflow_o = 1'b1;
        end else if (exp_rnd < 1) begin
            result_o = '{sign: norm_i.sign, exp: '0, frac: '0};     // Below normal range
        end else begin
            result_o = '{sign: norm_i.sign,
                         exp:  exp_rnd[`FMA_EXP_W-1:0],
                         frac: sig_rnd[`FMA_MANT_W-1:0]};
        end
    end

endmodule

/* source/fma_add_norm.sv */
`timescale 1ns/1ps
`include "fma_consts.svh"

module fma_add_norm (
    input  fma_pkg::align_t      align_i,
    input  fma_pkg::product_cs_t prod_i,
    output fma_pkg::norm_t       norm_o
);

    localparam int AW    = `FMA_ALIGN_W;
    localparam int PW    = 2 * (`FMA_MANT_W + 1);
    localparam int KEEP  = `FMA_MANT_W + 3;   // Significand, guard, round
    localparam int EW    = `FMA_EXP_W + 2;

    logic [AW-1:0] addend;
    logic [AW:0]   addend_x;   // One extra bit for the sign of the sum
    logic          cin;
    logic          inj;
    logic [AW:0]   total;
    logic          negative;
    logic [AW-1:0] mag;
    logic [6:0]    lz;
    logic [AW-1:0] shifted;
    logic          is_zero;

    ////////////////////////////////////////////////////////////
    // Three way add
    ////////////////////////////////////////////////////////////
    assign addend   = align_i.halt ? '0 : align_i.addend;   // Lives only in sticky
    assign addend_x = align_i.sub ? {1'b1, ~addend} : {1'b0, addend};

    // Sticky bits under A mean the true addend is slightly larger,
    // so skip the +1 and let the sum truncate toward the real value
    assign cin = align_i.sub & ~(align_i.sticky & ~align_i.shift_neg);

    // Tiny product stands in as one lsb under A
    assign inj = align_i.shift_neg & align_i.sticky;

    assign total = {{(AW-PW+1){1'b0}}, prod_i.sum}
                 + {{(AW-PW+1){1'b0}}, prod_i.carry}
                 + addend_x + cin + inj;

    assign negative = total[AW];
    assign mag      = negative ? (~total[AW-1:0] + 1'b1) : total[AW-1:0];
    assign is_zero  = (mag == '0);

    ////////////////////////////////////////////////////////////
    // Leading zeros and normalize
    ////////////////////////////////////////////////////////////
    always_comb begin
        lz = 7'(AW);   // All zero
        for (int k = 0; k < AW; k++) begin
            if (mag[k]) begin
                lz = 7'(AW - 1 - k);   // Highest set bit wins
            end
        end
    end

    assign shifted = mag << lz;

    always_comb begin
        if (is_zero) begin
            norm_o.sign = align_i.sign & ~align_i.sub;   // Exact cancel gives +0
        end else begin
            norm_o.sign = align_i.sign ^ negative;
        end
        norm_o.exp    = align_i.exp - $signed({{(EW-7){1'b0}}, lz});
        norm_o.mant   = shifted[AW-1 -: KEEP];
        norm_o.sticky = (|shifted[AW-KEEP-1:0]) | align_i.sticky;
        norm_o.zero   = is_zero;
    end

endmodule

/* source/fma_aligner.sv */
`timescale 1ns/1ps
`include "fma_consts.svh"

module fma_aligner (
    input  fma_pkg::fp_word_t    a_i,     // Addend
    input  fma_pkg::fp_word_t    b_i,
    input  fma_pkg::fp_word_t    c_i,
    input  fma_pkg::product_cs_t prod_i,  // B x C, redundant form
    output fma_pkg::align_t      align_o,
    output fma_pkg::product_cs_t prod_o   // Zeroed when A dominates
);

    localparam int EW    = `FMA_EXP_W + 2;  // Signed working exponent
    localparam int SIG_W = `FMA_MANT_W + 1;

    localparam logic signed [EW-1:0] BIAS  = `FMA_BIAS;
    localparam logic signed [EW-1:0] POINT = `FMA_POINT_OFS;
    localparam logic signed [EW-1:0] WIN   = `FMA_ALIGN_W;

    logic                    a_zero;
    logic                    p_zero;
    logic [SIG_W-1:0]        a_sig;
    logic signed [EW-1:0]    exp_a;
    logic signed [EW-1:0]    exp_prod;   // eb + ec - bias
    logic signed [EW-1:0]    exp_mv;     // Right shift of A, 27 - d
    logic                    shift_neg;
    logic                    halt;
    logic [6:0]              shamt;
    logic [`FMA_ALIGN_W-1:0] a_aligned;
    logic [SIG_W-1:0]        drop_bits;  // Shifted out below the window

    // Subnormals already flushed, exponent 0 means zero
    assign a_zero = (a_i.exp == '0);
    assign p_zero = (b_i.exp == '0) | (c_i.exp == '0);
    assign a_sig  = {~a_zero, a_i.frac};

    assign exp_a    = $signed({2'b00, a_i.exp});
    assign exp_prod = $signed({2'b00, b_i.exp}) + $signed({2'b00, c_i.exp}) - BIAS;
    assign exp_mv   = POINT + exp_prod - exp_a;

    // Zero product always leaves A alone, zero A always drops out
    assign shift_neg = p_zero | (~a_zero & exp_mv[EW-1]);
    assign halt      = ~shift_neg & (a_zero | (exp_mv >= WIN));

    // Out of range shift clamps to 0, add/norm then drops the addend
    assign shamt = (shift_neg | halt) ? 7'd0 : exp_mv[6:0];
    assign {a_aligned, drop_bits} = {a_sig, {`FMA_ALIGN_W{1'b0}}} >> shamt;

    always_comb begin
        align_o.sub       = a_i.sign ^ b_i.sign ^ c_i.sign;
        align_o.addend    = a_aligned;
        align_o.exp       = shift_neg ? exp_a : (exp_prod + POINT);  // Window msb weight
        align_o.sign      = b_i.sign ^ c_i.sign;
        align_o.shift_neg = shift_neg;
        align_o.halt      = halt;
        if (shift_neg) begin
            align_o.sticky = |{prod_i.sum, prod_i.carry};   // Product far below A
        end else if (halt) begin
            align_o.sticky = |a_sig;
        end else begin
            align_o.sticky = |drop_bits;
        end
    end

    assign prod_o = shift_neg ? '0 : prod_i;

endmodule

/* source/fma_multiplier.sv */
`timescale 1ns/1ps
`include "fma_consts.svh"

module fma_multiplier (
    input  logic [`FMA_MANT_W:0]  b_mant_i,  // 1.f of B, hidden bit included
    input  logic [`FMA_MANT_W:0]  c_mant_i,  // 1.f of C
    output fma_pkg::product_cs_t  prod_o
);

    localparam int SIG_W  = `FMA_MANT_W + 1;
    localparam int PROD_W = 2 * SIG_W;

    // One partial product per bit of C
    logic [PROD_W-1:0] pp [SIG_W];

    // Running sum and carry after each CSA row
    logic [PROD_W-1:0] row_sum   [1:SIG_W-1];
    logic [PROD_W-1:0] row_carry [1:SIG_W-1];

    genvar i;

    ////////////////////////////////////////////////////////////
    // Partial products
    ////////////////////////////////////////////////////////////
    generate
        for (i = 0; i < SIG_W; i++) begin : g_pp
            assign pp[i] = {{SIG_W{1'b0}}, b_mant_i & {SIG_W{c_mant_i[i]}}} << i;
        end
    endgenerate

    ////////////////////////////////////////////////////////////
    // Linear 3:2 array
    ////////////////////////////////////////////////////////////
    // First row just passes two products
    assign row_sum[1]   = pp[0];
    assign row_carry[1] = pp[1];

    // Each row folds one more product in
    // Operands are non-negative and the total stays below 2^48,
    // so no carry is ever pushed past bit 47
    generate
        for (i = 2; i < SIG_W; i++) begin : g_csa
            assign row_sum[i] = row_sum[i-1] ^ row_carry[i-1] ^ pp[i];
            assign row_carry[i] = ((row_sum[i-1] & row_carry[i-1])
                                 | (row_sum[i-1] & pp[i])
                                 | (row_carry[i-1] & pp[i])) << 1;   // Majority, weight up
        end
    endgenerate

    // Carry-propagate add happens in fma_add_norm
    assign prod_o.sum   = row_sum[SIG_W-1];
    assign prod_o.carry = row_carry[SIG_W-1];

endmodule

/* source/fma_pkg.sv */
`include "fma_consts.svh"

package fma_pkg;

    // IEEE single word
    typedef struct packed {
        logic                   sign;
        logic [`FMA_EXP_W-1:0]  exp;
        logic [`FMA_MANT_W-1:0] frac;
    } fp_word_t;

    // Product kept redundant until the three way add
    typedef struct packed {
        logic [2*`FMA_MANT_W+1:0] sum;
        logic [2*`FMA_MANT_W+1:0] carry;
    } product_cs_t;

    typedef struct packed {
        logic                         sub;       // Effective subtract
        logic [`FMA_ALIGN_W-1:0]      addend;    // A significand in window
        logic signed [`FMA_EXP_W+1:0] exp;       // Biased weight of window msb
        logic                         sign;      // Product sign, flipped later if needed
        logic                         shift_neg; // A dominates, product in sticky
        logic                         halt;      // A below window, only in sticky
        logic                         sticky;
    } align_t;

    typedef struct packed {
        logic                         sign;
        logic signed [`FMA_EXP_W+1:0] exp;
        logic [`FMA_MANT_W+2:0]       mant;   // 1.f plus guard and round
        logic                         sticky;
        logic                         zero;
    } norm_t;

    // Wishbone classic, word addressed
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [4:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

/* include/fma_consts.svh */
`ifndef FMA_CONSTS_SVH
`define FMA_CONSTS_SVH

////////////////////////////////////////////////////////////
// Single precision format
////////////////////////////////////////////////////////////
`define FMA_EXP_W      8      // Exponent field
`define FMA_MANT_W     23     // Stored fraction, hidden bit not counted
`define FMA_BIAS       127

////////////////////////////////////////////////////////////
// Datapath geometry
////////////////////////////////////////////////////////////
`define FMA_ALIGN_W    74     // Addend window, product sits in the low 48 bits
`define FMA_POINT_OFS  27     // Product point to addend top when exponents match

////////////////////////////////////////////////////////////
// Wishbone register map, byte offsets
////////////////////////////////////////////////////////////
`define FMA_ADDR_A      7'h00
`define FMA_ADDR_B      7'h04
`define FMA_ADDR_C      7'h08
`define FMA_ADDR_CTRL   7'h0C // Bit 0 starts the core
`define FMA_ADDR_STATUS 7'h10 // {overflow, done, busy}
`define FMA_ADDR_RESULT 7'h14

`endif
